/* hdl/csr_pkg.sv */
/*
 * shared definitions of the machine-mode CSR subsystem
 * field widths and types, access op codes, CSR addresses,
 * misa value, trap cause codes and command FIFO sizing
 */

`default_nettype none

package csr_pkg;

    // field widths
    localparam int CSR_ADDR_W     = 12;
    localparam int CSR_DATA_W     = 32;
    localparam int CSR_OP_W       = 2;
    localparam int CSR_CMD_W      = CSR_OP_W + CSR_ADDR_W + CSR_DATA_W;   // 46 bit entry
    localparam int CSR_CREDIT_W   = 3;
    localparam int CSR_FIFO_PTR_W = 2;

    typedef logic [CSR_ADDR_W-1:0]   csr_addr_t;
    typedef logic [CSR_DATA_W-1:0]   csr_data_t;
    typedef logic [CSR_OP_W-1:0]     csr_op_t;
    // {op, addr, data}, op in the top bits
    typedef logic [CSR_CMD_W-1:0]    csr_cmd_word_t;
    typedef logic [CSR_CREDIT_W-1:0] csr_credit_t;

    // access operations
    localparam csr_op_t CSR_OP_READ  = 2'b00;   // no write back
    localparam csr_op_t CSR_OP_WRITE = 2'b01;
    localparam csr_op_t CSR_OP_SET   = 2'b10;   // reg | data
    localparam csr_op_t CSR_OP_CLEAR = 2'b11;   // reg & ~data

    // machine-mode CSR addresses
    localparam csr_addr_t CSR_MISA_A     = 12'h301;
    localparam csr_addr_t CSR_MTVEC_A    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH_A = 12'h340;
    localparam csr_addr_t CSR_MEPC_A     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE_A   = 12'h342;
    localparam csr_addr_t CSR_MTVAL_A    = 12'h343;
    localparam csr_addr_t CSR_MCYCLE_A   = 12'hB00;

    // RV32I, MXL = 1 and the I extension bit
    localparam csr_data_t CSR_MISA_VALUE = 32'h4000_0100;

    // mcause exception codes
    localparam csr_data_t CAUSE_INSTR_MISALIGNED = 32'd0;
    localparam csr_data_t CAUSE_LOAD_MISALIGNED  = 32'd4;
    localparam csr_data_t CAUSE_STORE_MISALIGNED = 32'd6;

    // command queue entries, also the initial credit count
    localparam csr_credit_t CSR_FIFO_DEPTH = 3'd4;

endpackage : csr_pkg

`default_nettype wire

/* hdl/csr_req_issuer.sv */
/*
 * CSR request issuer
 * accepts core accesses against a credit counter and pushes
 * packed command words into the command FIFO
 */

`default_nettype none

module csr_req_issuer
(
    input  wire logic                   clk,
    input  wire logic                   resetn,
    // core side
    input  wire logic                   req_valid_i,
    input  wire csr_pkg::csr_op_t       req_op_i,
    input  wire csr_pkg::csr_addr_t     req_addr_i,
    input  wire csr_pkg::csr_data_t     req_wdata_i,
    output logic                        req_ready_o,
    // FIFO side
    input  wire logic                   credit_i,       // one pulse per freed entry
    output logic                        push_o,
    output csr_pkg::csr_cmd_word_t      push_word_o
);

    csr_pkg::csr_credit_t   credit_q;   // free FIFO entries as seen from here
    logic                   accept;

    assign req_ready_o = (credit_q != '0);
    assign accept      = req_valid_i & req_ready_o;

    // accepted request goes straight into the queue
    assign push_o      = accept;
    assign push_word_o = {req_op_i, req_addr_i, req_wdata_i};

    // spend on accept, refill on returned credit, both may coincide
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            credit_q <= csr_pkg::CSR_FIFO_DEPTH;
        else
        begin
            case ({accept, credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: ;  // no change or net zero
            endcase
        end
    end

    // counter stays within 0..depth, a wrap below zero shows up as a large value
    a_credit_range: assert property (
        @(posedge clk) disable iff (!resetn)
        credit_q <= csr_pkg::CSR_FIFO_DEPTH
    );

    // FIFO must never hand back more credits than were spent
    a_credit_overflow: assert property (
        @(posedge clk) disable iff (!resetn)
        !(credit_i && !accept && (credit_q == csr_pkg::CSR_FIFO_DEPTH))
    );

endmodule : csr_req_issuer

`default_nettype wire

/* hdl/csr_cmd_fifo.sv */
/*
 * CSR command FIFO
 * in-order circular buffer between issuer and CSR file,
 * returns one registered credit per pop
 */

`default_nettype none

module csr_cmd_fifo
(
    input  wire logic                       clk,
    input  wire logic                       resetn,
    // write side, from issuer
    input  wire logic                       push_i,
    input  wire csr_pkg::csr_cmd_word_t     push_word_i,
    // read side, to CSR file
    input  wire logic                       pop_i,
    output logic                            head_valid_o,
    output csr_pkg::csr_cmd_word_t          head_word_o,
    // credit return to issuer
    output logic                            credit_o
);

    csr_pkg::csr_cmd_word_t                 mem [csr_pkg::CSR_FIFO_DEPTH];
    logic [csr_pkg::CSR_FIFO_PTR_W-1:0]     wr_ptr_q;
    logic [csr_pkg::CSR_FIFO_PTR_W-1:0]     rd_ptr_q;
    csr_pkg::csr_credit_t                   count_q;    // occupancy 0..depth
    logic                                   credit_q;
    logic                                   full;

    assign full         = (count_q == csr_pkg::CSR_FIFO_DEPTH);
    assign head_valid_o = (count_q != '0);
    assign head_word_o  = mem[rd_ptr_q];
    assign credit_o     = credit_q;

    // storage
    always_ff @(posedge clk)
    begin
        if (push_i)
            mem[wr_ptr_q] <= push_word_i;
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end
        else
        begin
            if (push_i)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_i)
                rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            count_q <= '0;
        else
        begin
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    // freed entry becomes a credit one cycle later
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            credit_q <= 1'b0;
        else
            credit_q <= pop_i;
    end

    // issuer credits must keep pushes away from a full queue
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!resetn)
        !(push_i && full)
    );

    // CSR file only pops a valid head
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!resetn)
        !(pop_i && !head_valid_o)
    );

endmodule : csr_cmd_fifo

`default_nettype wire

/* hdl/csr_file.sv */
/*
 * machine-mode CSR file
 * executes queued read/write/set/clear commands, records misaligned
 * traps into mepc/mcause/mtval and runs the mcycle counter
 */

`default_nettype none

module csr_file
(
    input  wire logic                       clk,
    input  wire logic                       resetn,
    // command queue head
    input  wire logic                       head_valid_i,
    input  wire csr_pkg::csr_cmd_word_t     head_word_i,
    input  wire logic                       hold_i,         // core stall
    output logic                            pop_o,
    // response to core
    output logic                            rsp_valid_o,
    output csr_pkg::csr_data_t              rsp_rdata_o,
    // trap capture
    input  wire logic                       trap_valid_i,
    input  wire csr_pkg::csr_data_t         trap_cause_i,
    input  wire csr_pkg::csr_data_t         trap_pc_i,
    input  wire csr_pkg::csr_data_t         trap_addr_i,
    // live register values
    output csr_pkg::csr_data_t              mtvec_o,
    output csr_pkg::csr_data_t              mepc_o
);

    csr_pkg::csr_op_t       cmd_op;
    csr_pkg::csr_addr_t     cmd_addr;
    csr_pkg::csr_data_t     cmd_data;

    csr_pkg::csr_data_t     old_val;    // register value before the command
    csr_pkg::csr_data_t     new_val;
    logic                   exec;
    logic                   wr_en;

    csr_pkg::csr_data_t     mcycle_q;
    csr_pkg::csr_data_t     mscratch_q;
    csr_pkg::csr_data_t     mtvec_q;
    csr_pkg::csr_data_t     mepc_q;
    csr_pkg::csr_data_t     mcause_q;
    csr_pkg::csr_data_t     mtval_q;

    logic                   rsp_valid_q;
    csr_pkg::csr_data_t     rsp_rdata_q;

    // unpack {op, addr, data}
    assign cmd_op   = head_word_i[csr_pkg::CSR_CMD_W-1 -: csr_pkg::CSR_OP_W];
    assign cmd_addr = head_word_i[csr_pkg::CSR_DATA_W +: csr_pkg::CSR_ADDR_W];
    assign cmd_data = head_word_i[csr_pkg::CSR_DATA_W-1:0];

    // one command per cycle, executed on the popping edge
    assign pop_o = head_valid_i & ~hold_i;
    assign exec  = pop_o;
    assign wr_en = exec && (cmd_op != csr_pkg::CSR_OP_READ);

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_rdata_o = rsp_rdata_q;
    assign mtvec_o     = mtvec_q;
    assign mepc_o      = mepc_q;

    // read mux, unknown addresses read as zero
    always_comb
    begin
        old_val = '0;
        case (cmd_addr)
            csr_pkg::CSR_MCYCLE_A:   old_val = mcycle_q;
            csr_pkg::CSR_MISA_A:     old_val = csr_pkg::CSR_MISA_VALUE;
            csr_pkg::CSR_MSCRATCH_A: old_val = mscratch_q;
            csr_pkg::CSR_MTVEC_A:    old_val = mtvec_q;
            csr_pkg::CSR_MEPC_A:     old_val = mepc_q;
            csr_pkg::CSR_MCAUSE_A:   old_val = mcause_q;
            csr_pkg::CSR_MTVAL_A:    old_val = mtval_q;
            default: ;
        endcase
    end

    // write value from op
    always_comb
    begin
        case (cmd_op)
            csr_pkg::CSR_OP_WRITE: new_val = cmd_data;
            csr_pkg::CSR_OP_SET:   new_val = old_val | cmd_data;
            csr_pkg::CSR_OP_CLEAR: new_val = old_val & ~cmd_data;
            default:               new_val = old_val;   // read
        endcase
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            mscratch_q <= '0;
        else if (wr_en && (cmd_addr == csr_pkg::CSR_MSCRATCH_A))
            mscratch_q <= new_val;
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            mtvec_q <= '0;
        else if (wr_en && (cmd_addr == csr_pkg::CSR_MTVEC_A))
            mtvec_q <= new_val;
    end

    // trap capture beats a command write in the same cycle
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            mepc_q   <= '0;
            mcause_q <= '0;
            mtval_q  <= '0;
        end
        else if (trap_valid_i)
        begin
            mepc_q   <= trap_pc_i;
            mcause_q <= trap_cause_i;
            mtval_q  <= trap_addr_i;   // faulting address
        end
        else if (wr_en)
        begin
            if (cmd_addr == csr_pkg::CSR_MEPC_A)
                mepc_q <= new_val;
            if (cmd_addr == csr_pkg::CSR_MCAUSE_A)
                mcause_q <= new_val;
            if (cmd_addr == csr_pkg::CSR_MTVAL_A)
                mtval_q <= new_val;
        end
    end

    // free running unless written
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            mcycle_q <= '0;
        else if (wr_en && (cmd_addr == csr_pkg::CSR_MCYCLE_A))
            mcycle_q <= new_val;
        else
            mcycle_q <= mcycle_q + 1'b1;
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            rsp_valid_q <= 1'b0;
        else
            rsp_valid_q <= exec;
    end

    always_ff @(posedge clk)
    begin
        if (exec)
            rsp_rdata_q <= old_val;
    end

    // every response answers exactly the pop one cycle earlier
    a_rsp_after_pop: assert property (
        @(posedge clk) disable iff (!resetn)
        rsp_valid_o |-> $past(pop_o)
    );

endmodule : csr_file

`default_nettype wire

/* hdl/csr_subsys_top.sv */
/*
 * CSR subsystem top level
 * request issuer, credit-based command FIFO and CSR file
 */

`default_nettype none

module csr_subsys_top
(
    input  wire logic                   clk,
    input  wire logic                   resetn,
    // core requests
    input  wire logic                   req_valid_i,
    input  wire csr_pkg::csr_op_t       req_op_i,
    input  wire csr_pkg::csr_addr_t     req_addr_i,
    input  wire csr_pkg::csr_data_t     req_wdata_i,
    output logic                        req_ready_o,
    input  wire logic                   hold_i,
    // traps
    input  wire logic                   trap_valid_i,
    input  wire csr_pkg::csr_data_t     trap_cause_i,
    input  wire csr_pkg::csr_data_t     trap_pc_i,
    input  wire csr_pkg::csr_data_t     trap_addr_i,
    // responses and live values
    output logic                        rsp_valid_o,
    output csr_pkg::csr_data_t          rsp_rdata_o,
    output csr_pkg::csr_data_t          mtvec_o,
    output csr_pkg::csr_data_t          mepc_o
);

    logic                       push;
    csr_pkg::csr_cmd_word_t     push_word;
    logic                       credit;         // FIFO -> issuer
    logic                       head_valid;
    csr_pkg::csr_cmd_word_t     head_word;
    logic                       pop;

    csr_req_issuer u_issuer
    (
        .clk            (clk),
        .resetn         (resetn),
        .req_valid_i    (req_valid_i),
        .req_op_i       (req_op_i),
        .req_addr_i     (req_addr_i),
        .req_wdata_i    (req_wdata_i),
        .req_ready_o    (req_ready_o),
        .credit_i       (credit),
        .push_o         (push),
        .push_word_o    (push_word)
    );

    csr_cmd_fifo u_fifo
    (
        .clk            (clk),
        .resetn         (resetn),
        .push_i         (push),
        .push_word_i    (push_word),
        .pop_i          (pop),
        .head_valid_o   (head_valid),
        .head_word_o    (head_word),
        .credit_o       (credit)
    );

    csr_file u_csr_file
    (
        .clk            (clk),
        .resetn         (resetn),
        .head_valid_i   (head_valid),
        .head_word_i    (head_word),
        .hold_i         (hold_i),
        .pop_o          (pop),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_rdata_o    (rsp_rdata_o),
        .trap_valid_i   (trap_valid_i),
        .trap_cause_i   (trap_cause_i),
        .trap_pc_i      (trap_pc_i),
        .trap_addr_i    (trap_addr_i),
        .mtvec_o        (mtvec_o),
        .mepc_o         (mepc_o)
    );

endmodule : csr_subsys_top

`default_nettype wire

/* dv/csr_tb_vectors.svh */
/*
 * ordered-access table for the CSR subsystem testbench
 * columns are op, address, write data and the expected response (old value)
 */

`ifndef CSR_TB_VECTORS_SVH
`define CSR_TB_VECTORS_SVH

typedef struct packed
{
    csr_pkg::csr_op_t       op;
    csr_pkg::csr_addr_t     addr;
    csr_pkg::csr_data_t     wdata;
    csr_pkg::csr_data_t     exp_rdata;  // register value before the access
} access_vec_t;

localparam int NUM_VECTORS = 18;

localparam access_vec_t VECTORS [NUM_VECTORS] = '{
    // mscratch, write then set, clear and read back
    '{csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_MSCRATCH_A, 32'h1234_5678, 32'h0000_0000},
    '{csr_pkg::CSR_OP_SET,   csr_pkg::CSR_MSCRATCH_A, 32'h0000_F00F, 32'h1234_5678},
    '{csr_pkg::CSR_OP_CLEAR, csr_pkg::CSR_MSCRATCH_A, 32'h1200_0007, 32'h1234_F67F},
    '{csr_pkg::CSR_OP_READ,  csr_pkg::CSR_MSCRATCH_A, 32'h0000_0000, 32'h0034_F678},
    // mtvec
    '{csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_MTVEC_A,    32'h8000_0100, 32'h0000_0000},
    '{csr_pkg::CSR_OP_SET,   csr_pkg::CSR_MTVEC_A,    32'h0000_0001, 32'h8000_0100},
    '{csr_pkg::CSR_OP_CLEAR, csr_pkg::CSR_MTVEC_A,    32'h0000_0101, 32'h8000_0101},
    '{csr_pkg::CSR_OP_READ,  csr_pkg::CSR_MTVEC_A,    32'h0000_0000, 32'h8000_0000},
    // mepc
    '{csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_MEPC_A,     32'h0000_2000, 32'h0000_0000},
    '{csr_pkg::CSR_OP_SET,   csr_pkg::CSR_MEPC_A,     32'h0000_0044, 32'h0000_2000},
    '{csr_pkg::CSR_OP_CLEAR, csr_pkg::CSR_MEPC_A,     32'h0000_2000, 32'h0000_2044},
    '{csr_pkg::CSR_OP_READ,  csr_pkg::CSR_MEPC_A,     32'h0000_0000, 32'h0000_0044},
    // misa is read only
    '{csr_pkg::CSR_OP_READ,  csr_pkg::CSR_MISA_A,     32'h0000_0000, csr_pkg::CSR_MISA_VALUE},
    '{csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_MISA_A,     32'hFFFF_FFFF, csr_pkg::CSR_MISA_VALUE},
    '{csr_pkg::CSR_OP_READ,  csr_pkg::CSR_MISA_A,     32'h0000_0000, csr_pkg::CSR_MISA_VALUE},
    // unknown address reads zero and keeps nothing
    '{csr_pkg::CSR_OP_WRITE, 12'h7C0,                 32'hDEAD_BEEF, 32'h0000_0000},
    '{csr_pkg::CSR_OP_READ,  12'h7C0,                 32'h0000_0000, 32'h0000_0000},
    '{csr_pkg::CSR_OP_READ,  csr_pkg::CSR_MSCRATCH_A, 32'h0000_0000, 32'h0034_F678}
};

// live outputs once the table has run
localparam csr_pkg::csr_data_t TABLE_MTVEC_FINAL = 32'h8000_0000;
localparam csr_pkg::csr_data_t TABLE_MEPC_FINAL  = 32'h0000_0044;

`endif

/* dv/csr_subsys_tb.sv */
/*
 * testbench for the CSR subsystem
 * reset, ordered-access table, traps, back-pressure, mcycle and latency
 */

`default_nettype none

module csr_subsys_tb;

    `include "csr_tb_vectors.svh"

    localparam int WAIT_LIMIT = 50;         // cycles per wait loop
    localparam int RUN_LIMIT  = 20000;      // time units for the whole run
    localparam csr_pkg::csr_data_t MCYCLE_SEED = 32'h0001_0000;

    logic                   clk;
    logic                   resetn;
    logic                   req_valid_i;
    csr_pkg::csr_op_t       req_op_i;
    csr_pkg::csr_addr_t     req_addr_i;
    csr_pkg::csr_data_t     req_wdata_i;
    logic                   req_ready_o;
    logic                   hold_i;
    logic                   trap_valid_i;
    csr_pkg::csr_data_t     trap_cause_i;
    csr_pkg::csr_data_t     trap_pc_i;
    csr_pkg::csr_data_t     trap_addr_i;
    logic                   rsp_valid_o;
    csr_pkg::csr_data_t     rsp_rdata_o;
    csr_pkg::csr_data_t     mtvec_o;
    csr_pkg::csr_data_t     mepc_o;

    int                     errors = 0;
    int                     tests = 0;
    int                     cyc = 0;            // rising edges so far
    csr_pkg::csr_data_t     rsp_q [$];
    int                     rsp_edge_q [$];     // edge that takes each response

    csr_subsys_top uut (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    // sampled mid-cycle, the core takes it at the next rising edge
    always @(negedge clk)
    begin
        if (resetn && rsp_valid_o)
        begin
            rsp_q.push_back(rsp_rdata_o);
            rsp_edge_q.push_back(cyc + 1);
        end
    end

    initial
    begin
        #RUN_LIMIT;
        $display("run limit reached, the testbench did not finish");
        $display("CHECKS FAILED");
        $finish;
    end

    // hold one request until the issuer takes it
    task automatic send_req(input csr_pkg::csr_op_t op, input csr_pkg::csr_addr_t addr,
                            input csr_pkg::csr_data_t data, output int acc_edge);
        int waited;
        waited      = 0;
        acc_edge    = -1;
        req_valid_i = 1'b1;
        req_op_i    = op;
        req_addr_i  = addr;
        req_wdata_i = data;
        while (!req_ready_o && waited < WAIT_LIMIT)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!req_ready_o)
        begin
            $display("timeout: request to address 0x%03h was never accepted", addr);
            errors++;
        end
        else
        begin
            @(posedge clk);     // transfer edge
            #1;
            acc_edge = cyc;
        end
        req_valid_i = 1'b0;
    endtask

    task automatic wait_rsps(input int n);
        int waited;
        waited = 0;
        while (rsp_q.size() < n && waited < WAIT_LIMIT)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (rsp_q.size() < n)
        begin
            $display("timeout: %0d responses expected, only %0d arrived", n, rsp_q.size());
            errors++;
        end
    endtask

    task automatic take_rsp(input string what, output csr_pkg::csr_data_t data,
                            output int rsp_edge);
        data     = '0;
        rsp_edge = -1;
        if (rsp_q.size() == 0)
        begin
            $display("no response arrived for %s", what);
            errors++;
        end
        else
        begin
            data     = rsp_q.pop_front();
            rsp_edge = rsp_edge_q.pop_front();
        end
    endtask

    task automatic compare_rsp(input string what, input csr_pkg::csr_data_t exp);
        csr_pkg::csr_data_t got;
        int                 rsp_edge;
        take_rsp(what, got, rsp_edge);
        if (rsp_edge >= 0 && got !== exp)
        begin
            $display("FAIL %0t: %s returned 0x%08h, expected 0x%08h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before)
            $display("test %-16s ok", name);
        else
            $display("test %-16s %0d errors", name, errors - errors_before);
    endtask

    task automatic run_reset();
        int base;
        base        = errors;
        resetn      = 1'b0;
        req_valid_i = 1'b0;
        req_op_i    = csr_pkg::CSR_OP_READ;
        req_addr_i  = '0;
        req_wdata_i = '0;
        hold_i      = 1'b0;
        trap_valid_i = 1'b0;
        trap_cause_i = '0;
        trap_pc_i    = '0;
        trap_addr_i  = '0;
        repeat (5) @(posedge clk);
        #1;
        resetn = 1'b1;
        if (!req_ready_o || rsp_valid_o || mtvec_o !== '0 || mepc_o !== '0)
        begin
            $display("FAIL %0t: outputs after reset ready=%b rsp_valid=%b mtvec=0x%08h mepc=0x%08h",
                     $time, req_ready_o, rsp_valid_o, mtvec_o, mepc_o);
            errors++;
        end
        report_test("reset", base);
    endtask

    // whole table back to back, responses checked in order
    task automatic run_table();
        int base;
        int acc_edge;
        base = errors;
        for (int i = 0; i < NUM_VECTORS; i++)
            send_req(VECTORS[i].op, VECTORS[i].addr, VECTORS[i].wdata, acc_edge);
        wait_rsps(NUM_VECTORS);
        for (int i = 0; i < NUM_VECTORS; i++)
            compare_rsp($sformatf("table entry %0d", i), VECTORS[i].exp_rdata);
        if (mtvec_o !== TABLE_MTVEC_FINAL || mepc_o !== TABLE_MEPC_FINAL)
        begin
            $display("FAIL %0t: mtvec_o 0x%08h mepc_o 0x%08h after table", $time, mtvec_o,
                     mepc_o);
            errors++;
        end
        report_test("ordered access", base);
    endtask

    // cause 0 comes after a nonzero cause so its mcause read shows a real update
    task automatic run_traps();
        int                 base;
        int                 acc_edge;
        csr_pkg::csr_data_t causes [3];
        csr_pkg::csr_data_t pcs [3];
        csr_pkg::csr_data_t addrs [3];
        base   = errors;
        causes = '{csr_pkg::CAUSE_LOAD_MISALIGNED, csr_pkg::CAUSE_INSTR_MISALIGNED,
                   csr_pkg::CAUSE_STORE_MISALIGNED};
        pcs    = '{32'h0000_2010, 32'h0000_1002, 32'h0000_2024};
        addrs  = '{32'h0000_3003, 32'h0000_1002, 32'h0000_4005};
        for (int i = 0; i < 3; i++)
        begin
            trap_valid_i = 1'b1;    // one-cycle pulse
            trap_cause_i = causes[i];
            trap_pc_i    = pcs[i];
            trap_addr_i  = addrs[i];
            @(posedge clk);
            #1;
            trap_valid_i = 1'b0;
            if (mepc_o !== pcs[i])
            begin
                $display("FAIL %0t: mepc_o 0x%08h after trap %0d", $time, mepc_o, i);
                errors++;
            end
            send_req(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MEPC_A, '0, acc_edge);
            send_req(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MCAUSE_A, '0, acc_edge);
            send_req(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MTVAL_A, '0, acc_edge);
            wait_rsps(3);
            compare_rsp($sformatf("mepc after trap %0d", i), pcs[i]);
            compare_rsp($sformatf("mcause after trap %0d", i), causes[i]);
            compare_rsp($sformatf("mtval after trap %0d", i), addrs[i]);
        end
        report_test("traps", base);
    endtask

    task automatic run_backpressure();
        int                 base;
        int                 acc_edge;
        int                 accepted;
        csr_pkg::csr_data_t sent [$];
        csr_pkg::csr_data_t prev;
        base = errors;
        prev = 32'h5A5A_0F0F;
        send_req(csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_MSCRATCH_A, prev, acc_edge);
        wait_rsps(1);
        rsp_q.delete();         // old mscratch value, not part of this test
        rsp_edge_q.delete();
        hold_i   = 1'b1;
        accepted = 0;
        // offer six writes, credits run out after four
        for (int i = 0; i < 6; i++)
        begin
            req_valid_i = 1'b1;
            req_op_i    = csr_pkg::CSR_OP_WRITE;
            req_addr_i  = csr_pkg::CSR_MSCRATCH_A;
            req_wdata_i = $urandom;
            if (!req_ready_o)
                break;
            sent.push_back(req_wdata_i);
            @(posedge clk);
            #1;
            accepted++;
        end
        req_valid_i = 1'b0;
        if (accepted != 4 || req_ready_o)
        begin
            $display("FAIL %0t: %0d writes accepted under hold, ready=%b", $time, accepted,
                     req_ready_o);
            errors++;
        end
        repeat (3) @(posedge clk);
        #1;
        if (rsp_q.size() != 0)
        begin
            $display("FAIL %0t: response arrived while hold was high", $time);
            errors++;
        end
        hold_i = 1'b0;
        send_req(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MSCRATCH_A, '0, acc_edge);
        wait_rsps(accepted + 1);
        for (int i = 0; i < accepted; i++)
        begin
            compare_rsp($sformatf("held write %0d", i), prev);
            prev = sent[i];
        end
        compare_rsp("mscratch read after hold", prev);
        report_test("back-pressure", base);
    endtask

    task automatic run_mcycle();
        int                 base;
        int                 acc_edge;
        int                 rsp_edge;
        csr_pkg::csr_data_t got;
        base = errors;
        send_req(csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_MCYCLE_A, MCYCLE_SEED, acc_edge);
        wait_rsps(1);
        take_rsp("mcycle write", got, rsp_edge);
        send_req(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MCYCLE_A, '0, acc_edge);
        wait_rsps(1);
        take_rsp("mcycle read", got, rsp_edge);
        if (!(got > MCYCLE_SEED && got <= MCYCLE_SEED + 32'd10))
        begin
            $display("FAIL %0t: mcycle read 0x%08h after writing 0x%08h", $time, got,
                     MCYCLE_SEED);
            errors++;
        end
        report_test("cycle counter", base);
    endtask

    task automatic run_latency();
        int                 base;
        int                 acc_edge;
        int                 rsp_edge;
        csr_pkg::csr_data_t got;
        base = errors;
        repeat (2) @(posedge clk);  // let credits settle
        #1;
        send_req(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MISA_A, '0, acc_edge);
        wait_rsps(1);
        take_rsp("latency read", got, rsp_edge);
        if (got !== csr_pkg::CSR_MISA_VALUE)
        begin
            $display("FAIL %0t: misa read 0x%08h", $time, got);
            errors++;
        end
        if (rsp_edge - acc_edge != 2)
        begin
            $display("FAIL %0t: latency %0d cycles, expected 2", $time, rsp_edge - acc_edge);
            errors++;
        end
        report_test("latency", base);
    endtask

    initial
    begin
        void'($urandom(32));
        run_reset();
        run_table();
        run_traps();
        run_backpressure();
        run_mcycle();
        run_latency();
        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule : csr_subsys_tb

`default_nettype wire

/* vlog.f */
+incdir+dv
hdl/csr_pkg.sv
hdl/csr_req_issuer.sv
hdl/csr_cmd_fifo.sv
hdl/csr_file.sv
hdl/csr_subsys_top.sv
dv/csr_subsys_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the CSR subsystem testbench with Verilator, runs it and checks the log

LOG=sim.log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert -f vlog.f --top-module csr_subsys_tb \
    --Mdir obj_dir -o csr_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/csr_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
